//--- all.f
design/album_mem_pkg.sv
design/album_clock_pkg.sv
design/mem_port_if.sv
design/photo_scaler.sv
design/time_keeper.sv
design/clock_overlay.sv
design/album_sequencer.sv
design/photo_album.sv
verif/tb_clock_gen.sv
verif/album_mem_model.sv
verif/tb_photo_album.sv

//--- design/album_clock_pkg.sv
`default_nettype none

package album_clock_pkg;

  // Slot timing in clock cycles
  localparam int SECOND_CYCLES = 1_000_000;
  localparam int SLOT_CYCLES   = 2_000_000;

  typedef logic [7:0] time_field_t;  // One of hour, minute, second
  typedef logic [3:0] digit_t;       // Decimal digit or glyph index

  ////////////////////////////////////////////////////////////
  // Font
  ////////////////////////////////////////////////////////////
  typedef logic [12:0] glyph_row_t;
  typedef logic [8:0]  cr_addr_t;

  localparam int GLYPH_W     = 13;
  localparam int GLYPH_H     = 24;
  localparam int GLYPH_COUNT = 8;   // hh:mm:ss

  localparam digit_t COLON_GLYPH = 4'd10;

endpackage

`default_nettype wire

//--- design/album_mem_pkg.sv
`default_nettype none

package album_mem_pkg;

  ////////////////////////////////////////////////////////////
  // Image memory words
  ////////////////////////////////////////////////////////////
  typedef logic [19:0] addr_t;
  typedef logic [23:0] pixel_t;   // Red on top, blue at the bottom
  typedef logic [7:0]  channel_t;

  localparam int CHANNELS = $bits(pixel_t) / $bits(channel_t);

  ////////////////////////////////////////////////////////////
  // Frame geometry
  ////////////////////////////////////////////////////////////
  localparam int FRAME_DIM   = 256;
  localparam int BIG_DIM     = 512;
  localparam int FRAME_WORDS = FRAME_DIM * FRAME_DIM;

  typedef logic [$clog2(FRAME_DIM)-1:0] coord_t;

  localparam addr_t OVERLAY_OFFSET = 20'd59543;  // Row 232, column 151

  // Header layout
  localparam addr_t HDR_TIME    = 20'd0;
  localparam addr_t HDR_FB_BASE = 20'd1;
  localparam addr_t HDR_COUNT   = 20'd2;
  localparam addr_t HDR_PHOTOS  = 20'd3;  // Address then size, per photo

  typedef enum logic {
    SIZE_256,
    SIZE_512
  } photo_size_e;

endpackage

`default_nettype wire

//--- design/album_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module album_sequencer
  import album_mem_pkg::*, album_clock_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  mem_port_if.sequencer     scale_port,
  mem_port_if.sequencer     draw_port,
  output addr_t             im_a,
  output pixel_t            im_d,
  output logic              im_wen,
  input  pixel_t            im_q,
  output logic              scale_start,
  output addr_t             photo_addr,
  output addr_t             fb_base,
  output photo_size_e       size,
  input  logic              scale_done,
  output logic              draw_start,
  input  logic              draw_done,
  output logic              load,
  output time_field_t [2:0] load_time,
  output logic              tick
);

  typedef enum logic [2:0] {
    HEADER,
    FETCH,
    SCALE,
    DRAW,
    HOLD
  } seq_state_e;

  seq_state_e                     state;
  logic [1:0]                     step;
  addr_t                          seq_addr;      // Own read address when no engine owns the port
  addr_t                          photo_count;
  addr_t                          photo_idx;
  addr_t                          next_idx;
  logic [$clog2(SLOT_CYCLES)-1:0] slot_cnt;
  logic                           slot_end;

  ////////////////////////////////////////////////////////////
  // Memory port routing
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (state)
      SCALE: begin
        im_a   = scale_port.addr;
        im_d   = scale_port.wdata;
        im_wen = scale_port.wen;
      end
      DRAW: begin
        im_a   = draw_port.addr;
        im_d   = draw_port.wdata;
        im_wen = draw_port.wen;
      end
      default: begin
        im_a   = seq_addr;
        im_d   = '0;
        im_wen = 1'b1;
      end
    endcase
  end

  assign scale_port.rdata = im_q;
  assign draw_port.rdata  = im_q;

  assign slot_end  = (slot_cnt == SLOT_CYCLES - 1);
  assign tick      = (state != HEADER) && (slot_cnt == SECOND_CYCLES - 1 || slot_end);
  assign load      = (state == HEADER) && (step == 2'd1);   // Word 0 on im_q
  assign load_time = im_q;
  assign next_idx  = (photo_idx + 1 >= photo_count) ? '0 : photo_idx + addr_t'(1);

  ////////////////////////////////////////////////////////////
  // Slot FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= HEADER;
      step        <= '0;
      seq_addr    <= HDR_TIME;
      slot_cnt    <= '0;
      photo_idx   <= '0;
      scale_start <= 1'b0;
      draw_start  <= 1'b0;
    end else begin
      scale_start <= 1'b0;
      draw_start  <= 1'b0;
      if (state != HEADER) slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;
      case (state)
        HEADER: begin
          step <= step + 2'd1;
          case (step)
            2'd0: seq_addr <= HDR_FB_BASE;
            2'd1: seq_addr <= HDR_COUNT;
            2'd3: begin
              seq_addr <= HDR_PHOTOS;   // Photo 0, slot 0 starts
              step     <= '0;
              state    <= FETCH;
            end
            default: ;
          endcase
        end
        FETCH: begin
          step <= step + 2'd1;
          if (step == 2'd0) seq_addr <= seq_addr + addr_t'(1);
          if (step == 2'd3) begin
            step        <= '0;
            scale_start <= 1'b1;
            state       <= SCALE;
          end
        end
        SCALE: begin
          if (scale_done) begin
            draw_start <= 1'b1;
            state      <= DRAW;
          end
        end
        DRAW: if (draw_done) state <= HOLD;
        HOLD: begin
          if (slot_end) begin
            photo_idx <= next_idx;
            seq_addr  <= addr_t'(HDR_PHOTOS + 2 * next_idx);
            state     <= FETCH;
          end
        end
        default: state <= HEADER;
      endcase
    end
  end

  // Header and photo words, one cycle behind their address
  always_ff @(posedge clk) begin
    if (state == HEADER && step == 2'd2) fb_base <= addr_t'(im_q);
    if (state == HEADER && step == 2'd3) photo_count <= addr_t'(im_q);
    if (state == FETCH && step == 2'd1) photo_addr <= addr_t'(im_q);
    if (state == FETCH && step == 2'd3) begin
      size <= (im_q == pixel_t'(BIG_DIM)) ? SIZE_512 : SIZE_256;
    end
  end

  // Engines hand the port back idle
  a_no_write_outside_engines: assert property (@(posedge clk) disable iff (reset)
    (state inside {HEADER, FETCH, HOLD}) |-> (im_wen && scale_port.wen && draw_port.wen));

endmodule

`default_nettype wire

//--- design/clock_overlay.sv
`timescale 1ns/10ps
`default_nettype none

module clock_overlay
  import album_mem_pkg::*, album_clock_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  mem_port_if.engine        mem,
  input  logic              start,
  input  addr_t             fb_base,
  input  logic              load,
  input  time_field_t [2:0] load_time,
  input  logic              tick,
  output cr_addr_t          cr_a,
  input  glyph_row_t        cr_q,
  output logic              done
);

  typedef enum logic [2:0] {
    OV_IDLE,
    OV_ROM,
    OV_WAIT,
    OV_WRITE,
    OV_FIN
  } ov_state_e;

  ov_state_e                      state;
  logic [$clog2(GLYPH_COUNT)-1:0] glyph;
  logic [$clog2(GLYPH_H)-1:0]     row;
  logic [$clog2(GLYPH_W)-1:0]     col;
  digit_t                         digits [6];
  digit_t                         glyph_idx;
  addr_t                          row_base;

  time_keeper u_time_keeper (
    .clk       (clk),
    .reset     (reset),
    .load      (load),
    .load_time (load_time),
    .tick      (tick),
    .digits    (digits)
  );

  always_comb begin
    case (glyph)
      3'd0:    glyph_idx = digits[0];
      3'd1:    glyph_idx = digits[1];
      3'd3:    glyph_idx = digits[2];
      3'd4:    glyph_idx = digits[3];
      3'd6:    glyph_idx = digits[4];
      3'd7:    glyph_idx = digits[5];
      default: glyph_idx = COLON_GLYPH;   // Positions 2 and 5
    endcase
  end

  assign row_base = fb_base + OVERLAY_OFFSET + addr_t'(row * FRAME_DIM + glyph * GLYPH_W);

  ////////////////////////////////////////////////////////////
  // Glyph row walk
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= OV_IDLE;
      glyph    <= '0;
      row      <= '0;
      col      <= '0;
      cr_a     <= '0;
      mem.addr <= '0;
      mem.wen  <= 1'b1;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        OV_IDLE: begin
          if (start) begin
            state <= OV_ROM;
            glyph <= '0;
            row   <= '0;
          end
        end
        OV_ROM: begin
          cr_a    <= cr_addr_t'(glyph_idx * GLYPH_H + row);
          mem.wen <= 1'b1;   // Last write of the previous row ends here
          col     <= '0;
          state   <= OV_WAIT;
        end
        OV_WAIT: state <= OV_WRITE;   // ROM read in flight
        OV_WRITE: begin
          mem.addr <= row_base + addr_t'(col);
          mem.wen  <= 1'b0;
          col      <= col + 1'b1;
          if (col == GLYPH_W - 1) begin
            if (row == GLYPH_H - 1) begin
              row <= '0;
              if (glyph == GLYPH_COUNT - 1) begin
                state <= OV_FIN;
              end else begin
                glyph <= glyph + 1'b1;
                state <= OV_ROM;
              end
            end else begin
              row   <= row + 1'b1;
              state <= OV_ROM;
            end
          end
        end
        OV_FIN: begin
          mem.wen <= 1'b1;
          done    <= 1'b1;
          state   <= OV_IDLE;
        end
        default: state <= OV_IDLE;
      endcase
    end
  end

  // White where the font bit is set, leftmost pixel in bit 12
  always_ff @(posedge clk) begin
    if (state == OV_WRITE) mem.wdata <= {$bits(pixel_t){cr_q[GLYPH_W - 1 - col]}};
  end

endmodule

`default_nettype wire

//--- design/mem_port_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if
  import album_mem_pkg::*;
();
  addr_t  addr;
  pixel_t wdata;
  logic   wen;     // Active low
  pixel_t rdata;

  modport engine (output addr, output wdata, output wen, input rdata);

  modport sequencer (input addr, input wdata, input wen, output rdata);
endinterface

`default_nettype wire

//--- design/photo_album.sv
`timescale 1ns/10ps
`default_nettype none

module photo_album
  import album_mem_pkg::*, album_clock_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  output addr_t      im_a,
  output pixel_t     im_d,
  output logic       im_wen,
  input  pixel_t     im_q,
  output cr_addr_t   cr_a,
  input  glyph_row_t cr_q
);

  mem_port_if scale_bus ();
  mem_port_if draw_bus ();

  logic              scale_start;
  logic              scale_done;
  logic              draw_start;
  logic              draw_done;
  logic              load;
  logic              tick;
  addr_t             photo_addr;
  addr_t             fb_base;
  photo_size_e       size;
  time_field_t [2:0] load_time;

  album_sequencer u_sequencer (
    .clk         (clk),
    .reset       (reset),
    .scale_port  (scale_bus.sequencer),
    .draw_port   (draw_bus.sequencer),
    .im_a        (im_a),
    .im_d        (im_d),
    .im_wen      (im_wen),
    .im_q        (im_q),
    .scale_start (scale_start),
    .photo_addr  (photo_addr),
    .fb_base     (fb_base),
    .size        (size),
    .scale_done  (scale_done),
    .draw_start  (draw_start),
    .draw_done   (draw_done),
    .load        (load),
    .load_time   (load_time),
    .tick        (tick)
  );

  photo_scaler u_scaler (
    .clk        (clk),
    .reset      (reset),
    .mem        (scale_bus.engine),
    .start      (scale_start),
    .photo_addr (photo_addr),
    .fb_base    (fb_base),
    .size       (size),
    .done       (scale_done)
  );

  clock_overlay u_overlay (
    .clk       (clk),
    .reset     (reset),
    .mem       (draw_bus.engine),
    .start     (draw_start),
    .fb_base   (fb_base),
    .load      (load),
    .load_time (load_time),
    .tick      (tick),
    .cr_a      (cr_a),
    .cr_q      (cr_q),
    .done      (draw_done)
  );

endmodule

`default_nettype wire

//--- design/photo_scaler.sv
`timescale 1ns/10ps
`default_nettype none

module photo_scaler
  import album_mem_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  mem_port_if.engine  mem,
  input  logic        start,
  input  addr_t       photo_addr,
  input  addr_t       fb_base,
  input  photo_size_e size,
  output logic        done
);

  typedef enum logic [1:0] {
    SC_IDLE,
    SC_RUN,
    SC_FIN
  } sc_state_e;

  sc_state_e  state;
  logic [2:0] step;
  coord_t     row;
  coord_t     col;
  logic [9:0] acc [CHANNELS];
  pixel_t     avg;
  addr_t      src_addr;
  addr_t      dst_addr;
  logic       last_step;
  logic       last_pixel;

  assign src_addr = (size == SIZE_512) ?
                    photo_addr + addr_t'(row * 2 * BIG_DIM + col * 2) :
                    photo_addr + addr_t'(row * FRAME_DIM + col);
  assign dst_addr = fb_base + addr_t'(row * FRAME_DIM + col);

  // Copy writes at step 2, shrink at step 5
  assign last_step  = (size == SIZE_512) ? (step == 3'd5) : (step == 3'd2);
  assign last_pixel = (row == coord_t'(FRAME_DIM - 1)) && (col == coord_t'(FRAME_DIM - 1));

  ////////////////////////////////////////////////////////////
  // Walk and memory port
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= SC_IDLE;
      step     <= '0;
      row      <= '0;
      col      <= '0;
      mem.addr <= '0;
      mem.wen  <= 1'b1;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        SC_IDLE: begin
          if (start) begin
            state <= SC_RUN;
            step  <= '0;
            row   <= '0;
            col   <= '0;
          end
        end
        SC_RUN: begin
          step <= last_step ? 3'd0 : step + 3'd1;
          case (step)
            3'd0: begin
              mem.addr <= src_addr;     // Also ends the previous write
              mem.wen  <= 1'b1;
            end
            3'd1: if (size == SIZE_512) mem.addr <= src_addr + addr_t'(1);
            3'd2: if (size == SIZE_512) mem.addr <= src_addr + addr_t'(BIG_DIM);
            3'd3: mem.addr <= src_addr + addr_t'(BIG_DIM + 1);
            default: ;
          endcase
          if (last_step) begin
            mem.addr <= dst_addr;
            mem.wen  <= 1'b0;
            col      <= col + coord_t'(1);
            if (col == coord_t'(FRAME_DIM - 1)) row <= row + coord_t'(1);
            if (last_pixel) state <= SC_FIN;
          end
        end
        SC_FIN: begin
          mem.wen <= 1'b1;
          done    <= 1'b1;
          state   <= SC_IDLE;
        end
        default: state <= SC_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // 2x2 averaging
  ////////////////////////////////////////////////////////////
  always_comb begin
    logic [9:0] sum;
    channel_t   in_ch;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      in_ch = mem.rdata[8*ch +: 8];
      sum = acc[ch] + 10'(in_ch);         // Fourth pixel straight from the bus
      avg[8*ch +: 8] = channel_t'(sum >> 2);
    end
  end

  always_ff @(posedge clk) begin
    if (state == SC_RUN) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (step == 3'd0) begin
          acc[ch] <= '0;
        end else if (step >= 3'd2 && step <= 3'd4) begin
          acc[ch] <= acc[ch] + 10'(mem.rdata[8*ch +: 8]);
        end
      end
      if (last_step) mem.wdata <= (size == SIZE_512) ? avg : mem.rdata;
    end
  end

  a_write_in_frame: assert property (@(posedge clk) disable iff (reset)
    !mem.wen |-> addr_t'(mem.addr - fb_base) < FRAME_WORDS);

endmodule

`default_nettype wire

//--- design/time_keeper.sv
`timescale 1ns/10ps
`default_nettype none

module time_keeper
  import album_clock_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              load,
  input  time_field_t [2:0] load_time,   // Hour, minute, second
  input  logic              tick,
  output digit_t            digits [6]   // h1 h0 m1 m0 s1 s0
);

  time_field_t hour;
  time_field_t minute;
  time_field_t second;

  // Tens by comparing against each multiple of ten
  function automatic digit_t tens_of(time_field_t value);
    digit_t tens;
    tens = '0;
    for (int t = 1; t < 10; t++) begin
      if (value >= time_field_t'(10 * t)) tens = digit_t'(t);
    end
    return tens;
  endfunction

  function automatic digit_t units_of(time_field_t value);
    time_field_t rest;
    rest = value - time_field_t'(10 * tens_of(value));
    return digit_t'(rest);
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hour   <= '0;
      minute <= '0;
      second <= '0;
    end else if (load) begin
      hour   <= load_time[2];
      minute <= load_time[1];
      second <= load_time[0];
    end else if (tick) begin
      if (second == 8'd59) begin
        second <= '0;
        if (minute == 8'd59) begin
          minute <= '0;
          hour   <= (hour == 8'd23) ? '0 : hour + 8'd1;   // Day wrap
        end else begin
          minute <= minute + 8'd1;
        end
      end else begin
        second <= second + 8'd1;
      end
    end
  end

  assign digits[0] = tens_of(hour);
  assign digits[1] = units_of(hour);
  assign digits[2] = tens_of(minute);
  assign digits[3] = units_of(minute);
  assign digits[4] = tens_of(second);
  assign digits[5] = units_of(second);

  a_time_in_range: assert property (@(posedge clk) disable iff (reset)
    second < 60 && minute < 60 && hour < 24);

endmodule

`default_nettype wire

//--- verif/album_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module album_mem_model
  import album_mem_pkg::*, album_clock_pkg::*;
(
  input  logic       clk,
  input  addr_t      im_a,
  input  pixel_t     im_d,
  input  logic       im_wen,
  output pixel_t     im_q,
  input  cr_addr_t   cr_a,
  output glyph_row_t cr_q
);

  pixel_t     img [addr_t];   // Sparse image memory
  glyph_row_t rom [512];
  pixel_t     rd_word;
  glyph_row_t rd_glyph;

  // Words never written read back as a mix of their address bits
  function automatic pixel_t fill_pattern(addr_t a);
    return {a[19:8] ^ 12'h5a3, a[11:0]};
  endfunction

  function automatic pixel_t read_word(addr_t a);
    if (img.exists(a)) return img[a];
    return fill_pattern(a);
  endfunction

  task automatic write_word(addr_t a, pixel_t d);
    img[a] = d;
  endtask

  function automatic glyph_row_t read_glyph(cr_addr_t a);
    return rom[a];
  endfunction

  task automatic write_glyph(cr_addr_t a, glyph_row_t d);
    rom[a] = d;
  endtask

  initial begin
    im_q = '0;
    cr_q = '0;
  end

  ////////////////////////////////////////////////////////////
  // Port timing
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    rd_word  = $isunknown(im_a) ? 'x : read_word(im_a);   // Read before write
    rd_glyph = rom[cr_a];
    if (im_wen === 1'b0) img[im_a] = im_d;
  end

  // Read data goes out on the falling edge
  always @(negedge clk) begin
    im_q <= rd_word;
    cr_q <= rd_glyph;
  end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  always #2 clk = ~clk;   // 4 ns period

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- verif/tb_photo_album.sv
`timescale 1ns/10ps
`default_nettype none

module tb_photo_album
  import album_mem_pkg::*, album_clock_pkg::*;
();

  localparam addr_t FB_BASE      = 20'h80000;
  localparam int    PHOTOS       = 2;
  localparam int    ROWS         = 3;
  localparam int    FILL_TIMEOUT = 2_500_000;
  localparam int    DRAW_TIMEOUT = 10_000;
  localparam int    OV_ROW       = OVERLAY_OFFSET / FRAME_DIM;
  localparam int    OV_COL       = OVERLAY_OFFSET % FRAME_DIM;
  localparam addr_t LAST_FILL    = FB_BASE + addr_t'(FRAME_WORDS - 1);
  localparam addr_t LAST_GLYPH   = FB_BASE + OVERLAY_OFFSET +
                                   addr_t'(FRAME_DIM * (GLYPH_H - 1) + GLYPH_W * GLYPH_COUNT - 1);

  typedef struct packed {
    addr_t       photo_addr;
    addr_t       photo_size;
    logic [7:0]  photo_idx;
    time_field_t hh;
    time_field_t mm;
    time_field_t ss;
  } slot_row_t;

  logic       clk;
  logic       reset;
  addr_t      im_a;
  pixel_t     im_d;
  logic       im_wen;
  pixel_t     im_q;
  cr_addr_t   cr_a;
  glyph_row_t cr_q;
  slot_row_t  slots [ROWS];
  addr_t      header_reads [$];
  logic       first_write_seen;
  int         error_count;

  tb_clock_gen clock_gen (.clk(clk), .reset(reset));

  album_mem_model mem_model (
    .clk(clk), .im_a(im_a), .im_d(im_d), .im_wen(im_wen), .im_q(im_q),
    .cr_a(cr_a), .cr_q(cr_q)
  );

  photo_album dut (
    .clk(clk), .reset(reset), .im_a(im_a), .im_d(im_d), .im_wen(im_wen), .im_q(im_q),
    .cr_a(cr_a), .cr_q(cr_q)
  );

  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic halt_on_failure();
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("FAILED %s: expected %h, actual %h", name, expected, actual);
      halt_on_failure();
    end
  endtask

  task automatic wait_for_write(addr_t target, int limit, string what);
    int   cycles;
    logic hit;
    cycles = 0;
    hit    = 1'b0;
    while (!hit && cycles < limit) begin
      @(posedge clk);
      hit = (im_wen === 1'b0) && (im_a == target);
      cycles++;
    end
    if (!hit) begin
      $display("Timed out waiting for the %s to write address %h", what, target);
      halt_on_failure();
    end else begin
      @(negedge clk);   // Memory model has taken the write
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Memory contents
  ////////////////////////////////////////////////////////////
  task automatic fill_memories();
    logic [31:0] seed;
    int          span;
    seed = 32'd95;
    for (int a = 0; a < 512; a++) begin
      seed = lcg_next(seed);
      mem_model.write_glyph(cr_addr_t'(a), seed[28:16]);
    end
    mem_model.write_word(HDR_TIME, {slots[0].hh, slots[0].mm, slots[0].ss});
    mem_model.write_word(HDR_FB_BASE, pixel_t'(FB_BASE));
    mem_model.write_word(HDR_COUNT, pixel_t'(PHOTOS));
    for (int i = 0; i < PHOTOS; i++) begin
      mem_model.write_word(HDR_PHOTOS + addr_t'(2 * i), pixel_t'(slots[i].photo_addr));
      mem_model.write_word(HDR_PHOTOS + addr_t'(2 * i + 1), pixel_t'(slots[i].photo_size));
      span = slots[i].photo_size * slots[i].photo_size;
      for (int a = 0; a < span; a++) begin
        seed = lcg_next(seed);
        mem_model.write_word(slots[i].photo_addr + addr_t'(a), seed[31:8]);
      end
    end
  endtask

  function automatic int glyph_for(int g, slot_row_t row);
    int idx;
    case (g)
      0:       idx = row.hh / 10;
      1:       idx = row.hh % 10;
      3:       idx = row.mm / 10;
      4:       idx = row.mm % 10;
      6:       idx = row.ss / 10;
      7:       idx = row.ss % 10;
      default: idx = COLON_GLYPH;
    endcase
    return idx;
  endfunction

  function automatic pixel_t average_block(pixel_t p0, pixel_t p1, pixel_t p2, pixel_t p3);
    int     sum;
    pixel_t res;
    for (int ch = 0; ch < 3; ch++) begin
      sum = p0[8*ch +: 8] + p1[8*ch +: 8] + p2[8*ch +: 8] + p3[8*ch +: 8];
      res[8*ch +: 8] = channel_t'(sum / 4);
    end
    return res;
  endfunction

  task automatic check_frame(int k);
    slot_row_t  row;
    addr_t      src;
    pixel_t     expected;
    glyph_row_t bits;
    int         g;
    string      name;
    string      photo_name;
    string      overlay_name;
    row          = slots[k];
    photo_name   = $sformatf("slot %0d photo %0d %s", k, row.photo_idx,
                             (row.photo_size == BIG_DIM) ? "average" : "copy");
    overlay_name = $sformatf("slot %0d overlay %02d:%02d:%02d", k, row.hh, row.mm, row.ss);
    for (int r = 0; r < FRAME_DIM; r++) begin
      for (int c = 0; c < FRAME_DIM; c++) begin
        if (r >= OV_ROW && c >= OV_COL && c < OV_COL + GLYPH_W * GLYPH_COUNT) begin
          g        = (c - OV_COL) / GLYPH_W;
          bits     = mem_model.read_glyph(cr_addr_t'(GLYPH_H * glyph_for(g, row) + r - OV_ROW));
          expected = bits[GLYPH_W - 1 - (c - OV_COL) % GLYPH_W] ? 24'hffffff : 24'h000000;
          name     = overlay_name;
        end else if (row.photo_size == BIG_DIM) begin
          src      = row.photo_addr + addr_t'(2 * r * BIG_DIM + 2 * c);
          expected = average_block(mem_model.read_word(src),
                                   mem_model.read_word(src + addr_t'(1)),
                                   mem_model.read_word(src + addr_t'(BIG_DIM)),
                                   mem_model.read_word(src + addr_t'(BIG_DIM + 1)));
          name     = photo_name;
        end else begin
          src      = row.photo_addr + addr_t'(r * FRAME_DIM + c);
          expected = mem_model.read_word(src);
          name     = photo_name;
        end
        check_value(name, expected, mem_model.read_word(FB_BASE + addr_t'(r * FRAME_DIM + c)));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Port watch
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (reset) begin
      if (im_wen !== 1'b1) begin
        $display("Write enable went low during reset");
        halt_on_failure();
      end
    end else begin
      if (header_reads.size() < 3) header_reads.push_back(im_a);
      if (im_wen === 1'b0) begin
        if (!first_write_seen) begin
          first_write_seen = 1'b1;
          check_value("first write is the slot 0 fill", FB_BASE, im_a);
        end
        if (addr_t'(im_a - FB_BASE) >= FRAME_WORDS) begin
          $display("A write landed outside the framebuffer at address %h", im_a);
          halt_on_failure();
        end
      end
    end
  end

  initial begin
    int cycles;
    error_count      = 0;
    first_write_seen = 1'b0;
    // Photo address, size, index, expected hh mm ss
    slots[0] = {20'h01000, 20'd256, 8'd0, 8'd23, 8'd59, 8'd58};
    slots[1] = {20'h20000, 20'd512, 8'd1, 8'd0, 8'd0, 8'd0};
    slots[2] = {20'h01000, 20'd256, 8'd0, 8'd0, 8'd0, 8'd2};   // Wraps to photo 0
    fill_memories();

    cycles = 0;
    while (reset !== 1'b0 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (reset !== 1'b0) begin
      $display("Reset was never released");
      halt_on_failure();
    end

    cycles = 0;
    while (header_reads.size() < 3 && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (header_reads.size() < 3) begin
      $display("The header reads never appeared on the memory port");
      halt_on_failure();
    end
    for (int i = 0; i < 3; i++) begin
      check_value($sformatf("header read %0d", i), i, header_reads[i]);
    end

    for (int k = 0; k < ROWS; k++) begin
      wait_for_write(LAST_FILL, FILL_TIMEOUT, "photo fill");
      wait_for_write(LAST_GLYPH, DRAW_TIMEOUT, "clock overlay");
      check_frame(k);
    end

    if (error_count == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("%0d checks failed", error_count);
      halt_on_failure();
    end
  end

endmodule

`default_nettype wire
